//--- Makefile
SIM      := verilator
FLAGS    := --binary -Wall -Wno-fatal
TOP      := tb_refcpu
FILELIST := tb.f

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- bench/ref_model.sv
`include "refcpu_params.svh"

module ref_model
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             advance,
    input  logic [`XLEN-1:0] fetch_adr,
    output logic [31:0]      fetch_word,
    output commit_t          expected
);
    localparam int PROG_WORDS = 512;
    localparam int IDX_W = $clog2(PROG_WORDS);
    localparam funct_t LEGAL_FN [26] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR, FN_JALR,
        FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
        FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU
    };

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] regs [`NREGS];
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] pc;
    logic        delay_pending;
    logic [31:0] delay_target;
    logic [31:0] branch_to;
    integer      seed;

    // the program wraps, so every fetch address lands on a program word
    assign fetch_word = prog[fetch_adr[IDX_W+1:2]];

    task automatic fill_program;
        logic [31:0] r;
        int          kind;
        int          t;
        for (int i = 0; i < PROG_WORDS; i++) begin
            r = $random(seed);
            kind = {$random(seed)} % 100;
            t = {$random(seed)} % PROG_WORDS;
            if (kind < 40) begin
                prog[i] = {6'h00, r[25:6], LEGAL_FN[int'(r[31:27]) % 26]};
            end else if (kind < 70) begin
                // ADDI through LUI are opcodes 0x08 to 0x0f
                prog[i] = {3'b001, r[31:29], r[25:0]};
            end else if (kind < 83) begin
                // equal registers make a taken BEQ likely
                prog[i] = {5'b00010, r[31], r[25:21], r[30] ? r[25:21] : r[20:16],
                           16'(t - i - 1)};
            end else if (kind < 93) begin
                prog[i] = {5'b00001, r[31], 26'(t)};
            end else begin
                prog[i] = r[31] ? {1'b1, r[30:0]} : {6'h00, r[25:6], r[30] ? 6'h3f : 6'h01};
            end
        end
    endtask

    task automatic predict;
        logic [31:0]     ins;
        logic [4:0]      rs;
        logic [4:0]      rt;
        logic [4:0]      rd;
        logic [4:0]      sh;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_s;
        logic [31:0]     imm_z;
        logic [31:0]     pc4;
        longint          wide;
        longint unsigned uwide;
        state_t          st;
        exc_t            ex;
        logic [4:0]      tgt;
        logic [31:0]     wv;
        logic [31:0]     nhi;
        logic [31:0]     nlo;
        ins = prog[pc[IDX_W+1:2]];
        rs = ins[25:21];
        rt = ins[20:16];
        rd = ins[15:11];
        sh = ins[10:6];
        a = regs[rs];
        b = regs[rt];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        imm_z = {16'h0, ins[15:0]};
        pc4 = pc + 4;
        st = S_COMMIT;
        ex = EX_NONE;
        wv = '0;
        nhi = hi;
        nlo = lo;
        if (ins[31:26] == OP_SPECIAL) begin
            tgt = rd;
            case (ins[5:0])
                FN_SLL:  wv = b << sh;
                FN_SRL:  wv = b >> sh;
                FN_SRA:  wv = $signed(b) >>> sh;
                FN_SLLV: wv = b << a[4:0];
                FN_SRLV: wv = b >> a[4:0];
                FN_SRAV: wv = $signed(b) >>> a[4:0];
                FN_ADDU: wv = a + b;
                FN_SUBU: wv = a - b;
                FN_AND:  wv = a & b;
                FN_OR:   wv = a | b;
                FN_XOR:  wv = a ^ b;
                FN_NOR:  wv = ~(a | b);
                FN_SLT:  wv = {31'b0, int'(a) < int'(b)};
                FN_SLTU: wv = {31'b0, a < b};
                FN_MFHI: wv = hi;
                FN_MFLO: wv = lo;
                FN_ADD, FN_SUB: begin
                    if (ins[5:0] == FN_ADD) begin
                        wide = longint'(int'(a)) + longint'(int'(b));
                    end else begin
                        wide = longint'(int'(a)) - longint'(int'(b));
                    end
                    // the true sum must survive truncation to 32 bits
                    if (wide != longint'(int'(wide[31:0]))) begin
                        ex = EX_OV;
                    end else begin
                        wv = wide[31:0];
                    end
                end
                FN_MTHI: begin
                    nhi = a;
                    tgt = 5'd0;
                end
                FN_MTLO: begin
                    nlo = a;
                    tgt = 5'd0;
                end
                FN_MULT: begin
                    wide = longint'(int'(a)) * longint'(int'(b));
                    {nhi, nlo} = wide;
                    tgt = 5'd0;
                end
                FN_MULTU: begin
                    uwide = 64'(a) * 64'(b);
                    {nhi, nlo} = uwide;
                    tgt = 5'd0;
                end
                FN_DIV: begin
                    tgt = 5'd0;
                    if (b == 0) begin
                        st = S_UNKNOWN;
                    end else begin
                        wide = longint'(int'(a)) / longint'(int'(b));
                        nlo = wide[31:0];
                        wide = longint'(int'(a)) % longint'(int'(b));
                        nhi = wide[31:0];
                    end
                end
                FN_DIVU: begin
                    tgt = 5'd0;
                    if (b == 0) begin
                        st = S_UNKNOWN;
                    end else begin
                        nlo = a / b;
                        nhi = a % b;
                    end
                end
                FN_JR: begin
                    st = S_BRANCH;
                    branch_to = a;
                    tgt = 5'd0;
                end
                FN_JALR: begin
                    st = S_BRANCH;
                    branch_to = a;
                    wv = pc + 8;
                end
                default: ex = EX_RI;
            endcase
        end else begin
            tgt = rt;
            case (ins[31:26])
                OP_ADDI: begin
                    wide = longint'(int'(a)) + longint'(int'(imm_s));
                    if (wide != longint'(int'(wide[31:0]))) begin
                        ex = EX_OV;
                    end else begin
                        wv = wide[31:0];
                    end
                end
                OP_ADDIU: wv = a + imm_s;
                OP_SLTI:  wv = {31'b0, int'(a) < int'(imm_s)};
                OP_SLTIU: wv = {31'b0, a < imm_s};
                OP_ANDI:  wv = a & imm_z;
                OP_ORI:   wv = a | imm_z;
                OP_XORI:  wv = a ^ imm_z;
                OP_LUI:   wv = {ins[15:0], 16'h0};
                OP_BEQ, OP_BNE: begin
                    tgt = 5'd0;
                    if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                        st = S_BRANCH;
                        branch_to = pc4 + (imm_s << 2);
                    end
                end
                OP_J, OP_JAL: begin
                    st = S_BRANCH;
                    branch_to = {pc4[31:28], ins[25:0], 2'b00};
                    tgt = (ins[31:26] == OP_JAL) ? 5'd31 : 5'd0;
                    wv = pc + 8;
                end
                default: ex = EX_RI;
            endcase
        end
        if (ex != EX_NONE) begin
            st = S_EXCEPTION;
            tgt = 5'd0;
        end
        if (tgt == 0) begin
            wv = '0;
        end
        expected = '{pc: pc, instr: ins, target_id: tgt, wdata: wv, hi: nhi, lo: nlo,
                     state: st, exc: ex};
    endtask

    task automatic retire;
        if (expected.state == S_EXCEPTION) begin
            pc = `EXC_VECTOR;
            delay_pending = 1'b0;
        end else begin
            if (expected.target_id != R0) begin
                regs[expected.target_id] = expected.wdata;
            end
            hi = expected.hi;
            lo = expected.lo;
            // a taken branch redirects after its delay slot
            pc = delay_pending ? delay_target : pc + 4;
            delay_pending = (expected.state == S_BRANCH);
            delay_target = branch_to;
        end
    endtask

    initial begin
        seed = 91;
        fill_program();
    end

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] = '0;
            end
            hi = '0;
            lo = '0;
            pc = `RESET_PC;
            delay_pending = 1'b0;
            delay_target = '0;
            branch_to = '0;
            predict();
        end else if (advance) begin
            retire();
            predict();
        end
    end
endmodule

//--- bench/tb_refcpu.sv
`include "refcpu_params.svh"

module tb_refcpu
    import core_pkg::*;
();
    localparam int NUM_COMMITS = 400;
    localparam int COMMIT_TIMEOUT = 200;

    logic             clk = 1'b0;
    logic             reset;
    logic             cyc;
    logic             stb;
    logic [`XLEN-1:0] adr;
    logic [31:0]      dat_i = '0;
    logic             ack = 1'b0;
    logic             commit_valid;
    commit_t          commit;
    logic             advance;
    logic [31:0]      mem_word;
    commit_t          expected;
    int               wait_left = 0;
    integer           ws_seed = 91;
    int               commits;
    logic             timed_out;

    refcpu_top refcpu_top_i (
        .clk          (clk),
        .reset        (reset),
        .cyc          (cyc),
        .stb          (stb),
        .adr          (adr),
        .dat_i        (dat_i),
        .ack          (ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    ref_model ref_model_i (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .fetch_adr  (adr),
        .fetch_word (mem_word),
        .expected   (expected)
    );

    always #2 clk = ~clk;

    // instruction memory slave with 0 to 3 wait states per transfer
    always @(negedge clk) begin
        // the master raises and drops stb together with cyc
        check_value("stb", 32'(stb), 32'(cyc));
        if (ack) begin
            ack = 1'b0;
            wait_left = $random(ws_seed) & 3;
        end else if (!reset && cyc && stb) begin
            // the fetch address is the pc of the next instruction to commit
            check_value("adr", adr, expected.pc);
            if (wait_left == 0) begin
                ack = 1'b1;
                dat_i = mem_word;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, want);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_commit;
        check_value("commit.pc", commit.pc, expected.pc);
        check_value("commit.instr", commit.instr, expected.instr);
        check_value("commit.target_id", 32'(commit.target_id), 32'(expected.target_id));
        check_value("commit.wdata", commit.wdata, expected.wdata);
        check_value("commit.hi", commit.hi, expected.hi);
        check_value("commit.lo", commit.lo, expected.lo);
        check_value("commit.state", 32'(commit.state), 32'(expected.state));
        check_value("commit.exc", 32'(commit.exc), 32'(expected.exc));
    endtask

    task automatic wait_commit(output logic lost);
        int cycles;
        cycles = 0;
        while (!commit_valid && cycles < COMMIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        lost = !commit_valid;
    endtask

    initial begin
        reset = 1'b1;
        advance = 1'b0;
        commits = 0;
        timed_out = 1'b0;
        repeat (2) @(negedge clk);
        // no bus cycle and no commit while reset is held
        check_value("cyc", 32'(cyc), 32'd0);
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        reset = 1'b0;
        while (commits < NUM_COMMITS && !timed_out) begin
            wait_commit(timed_out);
            if (!timed_out) begin
                check_commit();
                commits++;
                // model moves to the next instruction on the coming edge
                advance = 1'b1;
                @(negedge clk);
                advance = 1'b0;
            end
        end
        if (timed_out) begin
            $display("no commit within %0d cycles after %0d commits", COMMIT_TIMEOUT, commits);
            $display("TEST FAIL");
            $fatal(1, "commit timeout");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end
endmodule

//--- design/context_seq.sv
`include "refcpu_params.svh"

module context_seq
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic             fetch_req,
    output logic [`XLEN-1:0] fetch_pc,
    input  logic             fetch_done,
    input  logic             fetch_err,
    input  logic [31:0]      fetch_instr,
    output context_t         ctx,
    input  context_t         rtype_out,
    input  context_t         itype_out,
    output logic             commit_valid,
    output commit_t          commit
);
    context_t         exec_res;
    opcode_t          op;
    logic [`XLEN-1:0] wdata;

    assign op = opcode_t'(ctx.instr[31:26]);
    assign exec_res = (op == OP_SPECIAL) ? rtype_out : itype_out;

    assign fetch_req = (ctx.state == S_FETCH);
    assign fetch_pc = ctx.pc;

    // every post-execute state lasts one cycle and is the commit
    assign commit_valid = ctx.state inside {S_COMMIT, S_BRANCH, S_EXCEPTION, S_UNKNOWN};
    assign commit = '{
        pc:        ctx.pc,
        instr:     ctx.instr,
        target_id: ctx.target_id,
        wdata:     wdata,
        hi:        ctx.hi,
        lo:        ctx.lo,
        state:     ctx.state,
        exc:       ctx.exc
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            ctx <= '0;
            ctx.pc <= `RESET_PC;
            ctx.state <= S_FETCH;
            wdata <= '0;
        end else begin
            case (ctx.state)
                S_FETCH: begin
                    if (fetch_done) begin
                        ctx.instr <= fetch_instr;
                        if (fetch_err) begin
                            ctx.state <= S_EXCEPTION;
                            ctx.exc <= EX_BUS;
                            ctx.target_id <= R0;
                            wdata <= '0;
                        end else begin
                            ctx.state <= S_EXEC;
                        end
                    end
                end
                S_EXEC: begin
                    ctx.state <= exec_res.state;
                    ctx.exc <= exec_res.exc;
                    ctx.target_id <= exec_res.target_id;
                    ctx.hi <= exec_res.hi;
                    ctx.lo <= exec_res.lo;
                    ctx.args <= exec_res.args;
                    wdata <= (exec_res.target_id == R0) ? '0 : exec_res.r[exec_res.target_id];
                end
                default: begin
                    ctx.state <= S_FETCH;
                    ctx.exc <= EX_NONE;
                    if (ctx.state == S_EXCEPTION) begin
                        ctx.pc <= `EXC_VECTOR;
                        ctx.delay_pending <= 1'b0;
                        ctx.delay_target <= '0;
                    end else begin
                        if (ctx.target_id != R0) begin
                            ctx.r[ctx.target_id] <= wdata;
                        end
                        // a pending redirect takes effect after the delay slot
                        ctx.pc <= ctx.delay_pending ? ctx.delay_target : ctx.pc + 4;
                        ctx.delay_pending <= (ctx.state == S_BRANCH);
                        ctx.delay_target <= ctx.args.branch.new_pc;
                    end
                end
            endcase
        end
    end
endmodule

//--- design/core_pkg.sv
`include "refcpu_params.svh"

package core_pkg;

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_COMMIT,
        S_BRANCH,
        S_EXCEPTION,
        S_UNKNOWN
    } state_t;

    typedef enum logic [1:0] {
        EX_NONE,
        EX_RI,
        EX_OV,
        EX_BUS
    } exc_t;

    typedef struct packed {
        logic [`XLEN-1:0] new_pc;
    } branch_args_t;

    typedef struct packed {
        branch_args_t branch;
    } args_t;

    // whole architectural state plus the in-flight instruction
    typedef struct packed {
        logic [`XLEN-1:0]             pc;
        logic [31:0]                  instr;
        logic [`NREGS-1:0][`XLEN-1:0] r;
        logic [`XLEN-1:0]             hi;
        logic [`XLEN-1:0]             lo;
        state_t                       state;
        isa_pkg::reg_idx_t            target_id;
        exc_t                         exc;
        args_t                        args;
        logic                         delay_pending;
        logic [`XLEN-1:0]             delay_target;
    } context_t;

    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [31:0]       instr;
        isa_pkg::reg_idx_t target_id;
        logic [`XLEN-1:0]  wdata;
        logic [`XLEN-1:0]  hi;
        logic [`XLEN-1:0]  lo;
        state_t            state;
        exc_t              exc;
    } commit_t;

endpackage

//--- design/fetch_wb.sv
`include "refcpu_params.svh"

module fetch_wb (
    input  logic             clk,
    input  logic             reset,
    input  logic             fetch_req,
    input  logic [`XLEN-1:0] fetch_pc,
    output logic             fetch_done,
    output logic             fetch_err,
    output logic [31:0]      fetch_instr,
    output logic             cyc,
    output logic             stb,
    output logic [`XLEN-1:0] adr,
    input  logic [31:0]      dat_i,
    input  logic             ack
);
    localparam int TMO_W = $clog2(`FETCH_TIMEOUT + 1);

    logic [TMO_W-1:0] wait_cnt;
    logic             start;
    logic             timeout;

    // a request still high during the done cycle is the one just served
    assign start = !cyc && fetch_req && !fetch_done;
    assign timeout = cyc && !ack && (wait_cnt == TMO_W'(`FETCH_TIMEOUT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc <= 1'b0;
            stb <= 1'b0;
            fetch_done <= 1'b0;
            fetch_err <= 1'b0;
            wait_cnt <= '0;
        end else begin
            fetch_done <= 1'b0;
            if (start) begin
                cyc <= 1'b1;
                stb <= 1'b1;
                wait_cnt <= '0;
            end else if (cyc && (ack || timeout)) begin
                cyc <= 1'b0;
                stb <= 1'b0;
                fetch_done <= 1'b1;
                fetch_err <= timeout;
            end else if (cyc) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr <= fetch_pc;
        end
        if (cyc && ack) begin
            fetch_instr <= dat_i;
        end else if (timeout) begin
            fetch_instr <= '0;
        end
    end
endmodule

//--- design/isa_pkg.sv
`include "refcpu_params.svh"

package isa_pkg;

    typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

    localparam reg_idx_t R0 = '0;
    // link register for JAL
    localparam reg_idx_t RA = reg_idx_t'(31);

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_t;

    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06,
        FN_SRAV  = 6'h07,
        FN_JR    = 6'h08,
        FN_JALR  = 6'h09,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b,
        FN_ADD   = 6'h20,
        FN_ADDU  = 6'h21,
        FN_SUB   = 6'h22,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_NOR   = 6'h27,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_t;

    typedef struct packed {
        opcode_t    op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } rtype_t;

    typedef struct packed {
        opcode_t     op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } itype_t;

    typedef struct packed {
        opcode_t     op;
        logic [25:0] target;
    } jtype_t;

endpackage

//--- design/itype_exec.sv
`include "refcpu_params.svh"

module itype_exec
    import isa_pkg::*;
    import core_pkg::*;
(
    input  context_t ctx,
    output context_t out
);
    itype_t           f;
    jtype_t           j;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_z;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] jmp_target;
    logic [`XLEN:0]   add_x;

    assign f = itype_t'(ctx.instr);
    assign j = jtype_t'(ctx.instr);
    assign a = ctx.r[f.rs];
    assign b = ctx.r[f.rt];
    assign imm_s = {{(`XLEN-16){f.imm[15]}}, f.imm};
    assign imm_z = {{(`XLEN-16){1'b0}}, f.imm};
    assign pc_next = ctx.pc + 4;
    assign br_target = pc_next + (imm_s << 2);
    // region comes from the delay slot address
    assign jmp_target = {pc_next[`XLEN-1:28], j.target, 2'b00};
    assign add_x = {a[`XLEN-1], a} + {imm_s[`XLEN-1], imm_s};

    always_comb begin
        out = ctx;
        out.state = S_COMMIT;
        out.target_id = f.rt;

        unique case (f.op)
            OP_ADDI: begin
                if (add_x[`XLEN] != add_x[`XLEN-1]) begin
                    out.state = S_EXCEPTION;
                    out.exc = EX_OV;
                end else begin
                    out.r[f.rt] = add_x[`XLEN-1:0];
                end
            end
            OP_ADDIU: out.r[f.rt] = add_x[`XLEN-1:0];
            OP_SLTI:  out.r[f.rt] = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(imm_s)};
            OP_SLTIU: out.r[f.rt] = {{(`XLEN-1){1'b0}}, a < imm_s};
            OP_ANDI:  out.r[f.rt] = a & imm_z;
            OP_ORI:   out.r[f.rt] = a | imm_z;
            OP_XORI:  out.r[f.rt] = a ^ imm_z;
            OP_LUI:   out.r[f.rt] = {f.imm, 16'b0};
            OP_BEQ, OP_BNE: begin
                out.target_id = R0;
                if ((a == b) == (f.op == OP_BEQ)) begin
                    out.state = S_BRANCH;
                    out.args.branch.new_pc = br_target;
                end
            end
            OP_J: begin
                out.target_id = R0;
                out.state = S_BRANCH;
                out.args.branch.new_pc = jmp_target;
            end
            OP_JAL: begin
                out.target_id = RA;
                out.r[RA] = pc_next + 4;
                out.state = S_BRANCH;
                out.args.branch.new_pc = jmp_target;
            end
            default: begin
                out.state = S_EXCEPTION;
                out.exc = EX_RI;
            end
        endcase

        if (out.state == S_EXCEPTION) begin
            out.target_id = R0;
        end
    end
endmodule

//--- design/refcpu_params.svh
`ifndef REFCPU_PARAMS_SVH
`define REFCPU_PARAMS_SVH

// data and address width
`define XLEN 32

`define NREGS 32

`define RESET_PC 32'h0000_0000

// fixed cop0-style vector, no status or cause registers behind it
`define EXC_VECTOR 32'h0000_0180

// cycles without ack before the fetch is abandoned
`define FETCH_TIMEOUT 16

`endif

//--- design/refcpu_top.sv
`include "refcpu_params.svh"

module refcpu_top
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic             cyc,
    output logic             stb,
    output logic [`XLEN-1:0] adr,
    input  logic [31:0]      dat_i,
    input  logic             ack,
    output logic             commit_valid,
    output commit_t          commit
);
    logic             fetch_req;
    logic [`XLEN-1:0] fetch_pc;
    logic             fetch_done;
    logic             fetch_err;
    logic [31:0]      fetch_instr;
    context_t         ctx;
    context_t         rtype_out;
    context_t         itype_out;

    fetch_wb fetch_wb_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_done  (fetch_done),
        .fetch_err   (fetch_err),
        .fetch_instr (fetch_instr),
        .cyc         (cyc),
        .stb         (stb),
        .adr         (adr),
        .dat_i       (dat_i),
        .ack         (ack)
    );

    context_seq context_seq_i (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .fetch_done   (fetch_done),
        .fetch_err    (fetch_err),
        .fetch_instr  (fetch_instr),
        .ctx          (ctx),
        .rtype_out    (rtype_out),
        .itype_out    (itype_out),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    // both executors see every instruction, the sequencer picks by opcode
    rtype_exec rtype_exec_i (
        .ctx (ctx),
        .out (rtype_out)
    );

    itype_exec itype_exec_i (
        .ctx (ctx),
        .out (itype_out)
    );
endmodule

//--- design/rtype_exec.sv
`include "refcpu_params.svh"

module rtype_exec
    import isa_pkg::*;
    import core_pkg::*;
(
    input  context_t ctx,
    output context_t out
);
    rtype_t             f;
    logic [`XLEN-1:0]   a;
    logic [`XLEN-1:0]   b;
    logic [`XLEN-1:0]   link_pc;
    logic [`XLEN:0]     add_x;
    logic [`XLEN:0]     sub_x;
    logic [2*`XLEN-1:0] prod_s;
    logic [2*`XLEN-1:0] prod_u;

    assign f = rtype_t'(ctx.instr);
    assign a = ctx.r[f.rs];
    assign b = ctx.r[f.rt];
    assign link_pc = ctx.pc + 8;

    // extra top bit, overflow when it disagrees with bit 31
    assign add_x = {a[`XLEN-1], a} + {b[`XLEN-1], b};
    assign sub_x = {a[`XLEN-1], a} - {b[`XLEN-1], b};

    // low half of a wide product is the same for signed and unsigned operands
    assign prod_s = {{`XLEN{a[`XLEN-1]}}, a} * {{`XLEN{b[`XLEN-1]}}, b};
    assign prod_u = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};

    always_comb begin
        out = ctx;
        out.state = S_COMMIT;
        out.target_id = f.rd;

        unique case (f.funct)
            FN_SLL:  out.r[f.rd] = b << f.shamt;
            FN_SRL:  out.r[f.rd] = b >> f.shamt;
            FN_SRA:  out.r[f.rd] = $signed(b) >>> f.shamt;
            FN_SLLV: out.r[f.rd] = b << a[4:0];
            FN_SRLV: out.r[f.rd] = b >> a[4:0];
            FN_SRAV: out.r[f.rd] = $signed(b) >>> a[4:0];
            FN_ADDU: out.r[f.rd] = a + b;
            FN_SUBU: out.r[f.rd] = a - b;
            FN_AND:  out.r[f.rd] = a & b;
            FN_OR:   out.r[f.rd] = a | b;
            FN_XOR:  out.r[f.rd] = a ^ b;
            FN_NOR:  out.r[f.rd] = ~(a | b);
            FN_SLT:  out.r[f.rd] = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            FN_SLTU: out.r[f.rd] = {{(`XLEN-1){1'b0}}, a < b};
            FN_ADD: begin
                if (add_x[`XLEN] != add_x[`XLEN-1]) begin
                    out.state = S_EXCEPTION;
                    out.exc = EX_OV;
                end else begin
                    out.r[f.rd] = add_x[`XLEN-1:0];
                end
            end
            FN_SUB: begin
                if (sub_x[`XLEN] != sub_x[`XLEN-1]) begin
                    out.state = S_EXCEPTION;
                    out.exc = EX_OV;
                end else begin
                    out.r[f.rd] = sub_x[`XLEN-1:0];
                end
            end
            FN_MFHI: out.r[f.rd] = ctx.hi;
            FN_MTHI: out.hi = a;
            FN_MFLO: out.r[f.rd] = ctx.lo;
            FN_MTLO: out.lo = a;
            FN_MULT:  {out.hi, out.lo} = prod_s;
            FN_MULTU: {out.hi, out.lo} = prod_u;
            FN_DIV: begin
                // result undefined, hi and lo keep their value
                if (b == '0) begin
                    out.state = S_UNKNOWN;
                end else begin
                    out.lo = $signed(a) / $signed(b);
                    out.hi = $signed(a) % $signed(b);
                end
            end
            FN_DIVU: begin
                if (b == '0) begin
                    out.state = S_UNKNOWN;
                end else begin
                    out.lo = a / b;
                    out.hi = a % b;
                end
            end
            FN_JR: begin
                out.state = S_BRANCH;
                out.args.branch.new_pc = a;
            end
            FN_JALR: begin
                out.state = S_BRANCH;
                out.r[f.rd] = link_pc;
                out.args.branch.new_pc = a;
            end
            default: begin
                out.state = S_EXCEPTION;
                out.exc = EX_RI;
            end
        endcase

        // no register write for hi/lo producers, JR and faults
        if (out.state == S_EXCEPTION ||
            f.funct inside {FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_JR}) begin
            out.target_id = R0;
        end
    end
endmodule

//--- tb.f
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/rtype_exec.sv
design/itype_exec.sv
design/fetch_wb.sv
design/context_seq.sv
design/refcpu_top.sv
bench/ref_model.sv
bench/tb_refcpu.sv
